// File: all.f
common/lease_cache_pkg.sv
lease_cache/tag_memory_8way.sv
lease_cache/lease_table.sv
lease_cache/lease_cache_controller.sv
hdl/cache_data_memory.sv
hdl/cache_performance_controller.sv
hdl/lease_cache_8w.sv
verif/lease_cache_props.sv
verif/lease_cache_tb.sv

// File: common/lease_cache_pkg.sv
package lease_cache_pkg;

	// address split  [tag|set|word]
	localparam int BW_WORD_ADDR  = 16;
	localparam int BW_BLOCK      = 2;                                 // 4 words per block
	localparam int BW_SET        = 3;                                 // 8 sets
	localparam int BW_TAG        = BW_WORD_ADDR - BW_SET - BW_BLOCK;  // 11 bits
	localparam int NUM_WAYS      = 8;
	localparam int BW_WAY        = 3;
	localparam int BW_CACHE_ADDR = BW_SET + BW_WAY + BW_BLOCK;        // 256 cached words

	// lease and counter widths
	localparam int BW_LEASE   = 8;
	localparam int BW_REF_IDX = 4;   // 16 lease table entries
	localparam int BW_CNT     = 32;
	localparam int NUM_CNT    = 5;

	// comm opcodes, word bits 31:30
	localparam logic [1:0] COMM_OP_NOP         = 2'd0;
	localparam logic [1:0] COMM_OP_SET_LEASE   = 2'd1;
	localparam logic [1:0] COMM_OP_SET_DEFAULT = 2'd2;
	localparam logic [1:0] COMM_OP_READ_CNT    = 2'd3;

	// counter selectors
	localparam logic [2:0] CNT_HIT       = 3'd0;
	localparam logic [2:0] CNT_MISS      = 3'd1;
	localparam logic [2:0] CNT_WB        = 3'd2;
	localparam logic [2:0] CNT_EXPIRED   = 3'd3;
	localparam logic [2:0] CNT_DEFAULTED = 3'd4;

	// controller states
	localparam logic [2:0] ST_IDLE      = 3'd0;
	localparam logic [2:0] ST_LOOKUP    = 3'd1;
	localparam logic [2:0] ST_HIT       = 3'd2;
	localparam logic [2:0] ST_WRITEBACK = 3'd3;
	localparam logic [2:0] ST_FILL_REQ  = 3'd4;
	localparam logic [2:0] ST_FILL      = 3'd5;
	localparam logic [2:0] ST_BYPASS    = 3'd6;
	localparam logic [2:0] ST_DONE      = 3'd7;

	// one comm word, two decodings
	typedef union packed {
		struct packed {
			logic [1:0]            opcode;
			logic                  valid;   // entry valid on SET_LEASE
			logic [16:0]           rsvd;
			logic [BW_REF_IDX-1:0] index;
			logic [BW_LEASE-1:0]   lease;
		} lease_cfg;
		struct packed {
			logic [1:0]  opcode;
			logic [26:0] rsvd;
			logic [2:0]  sel;               // one of CNT_*
		} cnt_sel;
	} comm_word_u;

endpackage

// File: hdl/cache_data_memory.sv
`timescale 1ns/1ps

module cache_data_memory (
	input  logic                                      clock_i,
	input  logic [lease_cache_pkg::BW_CACHE_ADDR-1:0] addr_i,   // [set|way|word]
	input  logic [31:0]                               data_i,
	input  logic                                      wren_i,
	output logic [31:0]                               data_o
);

	logic [31:0] mem [2 ** lease_cache_pkg::BW_CACHE_ADDR];

	// registered read, old data on a write
	always_ff @(posedge clock_i) begin
		if (wren_i) mem[addr_i] <= data_i;
		data_o <= mem[addr_i];
	end

endmodule

// File: hdl/cache_performance_controller.sv
`timescale 1ns/1ps

module cache_performance_controller (
	input  logic        clock_i,
	input  logic        rst_n_i,
	input  logic        hit_i,
	input  logic        miss_i,
	input  logic        writeback_i,
	input  logic        expired_i,
	input  logic        defaulted_i,
	input  logic [31:0] comm_i,
	output logic [31:0] comm_o      // last counter read, held
);

	lease_cache_pkg::comm_word_u        comm;
	logic [lease_cache_pkg::NUM_CNT-1:0] event_v;
	logic [lease_cache_pkg::BW_CNT-1:0] cnt_q [lease_cache_pkg::NUM_CNT];

	assign comm = comm_i;

	always_comb begin
		event_v = '0;
		event_v[lease_cache_pkg::CNT_HIT]       = hit_i;
		event_v[lease_cache_pkg::CNT_MISS]      = miss_i;
		event_v[lease_cache_pkg::CNT_WB]        = writeback_i;
		event_v[lease_cache_pkg::CNT_EXPIRED]   = expired_i;
		event_v[lease_cache_pkg::CNT_DEFAULTED] = defaulted_i;
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < lease_cache_pkg::NUM_CNT; i++)
				cnt_q[i] <= '0;
			comm_o <= '0;
		end else begin
			for (int i = 0; i < lease_cache_pkg::NUM_CNT; i++) begin
				if (event_v[i] && cnt_q[i] != '1) cnt_q[i] <= cnt_q[i] + 1'b1;   // saturate
			end
			if (comm.cnt_sel.opcode == lease_cache_pkg::COMM_OP_READ_CNT)
				comm_o <= (comm.cnt_sel.sel < lease_cache_pkg::NUM_CNT)
					? cnt_q[comm.cnt_sel.sel] : '0;   // unused selectors read zero
		end
	end

endmodule

// File: hdl/lease_cache_8w.sv
`timescale 1ns/1ps

module lease_cache_8w (
	// system and comm
	input  logic                                     clock_i,
	input  logic                                     rst_n_i,
	input  logic [31:0]                              comm_i,
	output logic [31:0]                              comm_o,
	// core
	input  logic                                     core_req_i,
	input  logic [lease_cache_pkg::BW_WORD_ADDR-1:0] core_ref_add_i,
	input  logic                                     core_rw_i,      // 1 write
	input  logic [lease_cache_pkg::BW_WORD_ADDR-1:0] core_add_i,
	input  logic [31:0]                              core_data_i,
	output logic                                     core_done_o,
	output logic [31:0]                              core_data_o,
	// memory controller
	input  logic                                     en_i,
	input  logic                                     ready_req_i,
	input  logic                                     ready_write_i,
	input  logic                                     ready_read_i,
	input  logic [31:0]                              data_i,
	output logic                                     hit_o,
	output logic                                     req_o,
	output logic                                     req_block_o,
	output logic                                     rw_o,
	output logic                                     write_o,
	output logic                                     read_o,
	output logic [lease_cache_pkg::BW_WORD_ADDR-1:0] add_o,
	output logic [31:0]                              data_o
);

	logic [lease_cache_pkg::BW_TAG-1:0]   req_tag, victim_tag;
	logic [lease_cache_pkg::BW_SET-1:0]   req_set;
	logic [lease_cache_pkg::BW_BLOCK-1:0] req_word;
	logic [lease_cache_pkg::BW_WAY-1:0]   hit_way, victim_way, tag_way;
	logic [lease_cache_pkg::BW_LEASE-1:0] lease;
	logic [lease_cache_pkg::BW_CACHE_ADDR-1:0] cache_add;
	logic [31:0] data_to_cache, data_from_cache, ctrl_core_data;
	logic hit_tag, victim_dirty, victim_expired, defaulted;
	logic tag_lookup, tag_touch, tag_fill, tag_dirty, cache_wren, swap_flag;
	logic hit_flag, miss_flag, wb_flag, expired_flag, defaulted_flag;

	// address split  [tag|set|word]
	// ----------------------------------------
	assign req_tag  = core_add_i[lease_cache_pkg::BW_WORD_ADDR-1 -: lease_cache_pkg::BW_TAG];
	assign req_set  = core_add_i[lease_cache_pkg::BW_BLOCK +: lease_cache_pkg::BW_SET];
	assign req_word = core_add_i[lease_cache_pkg::BW_BLOCK-1:0];

	tag_memory_8way tag_mem_inst (
		.clock_i(clock_i), .rst_n_i(rst_n_i), .set_i(req_set), .tag_i(req_tag),
		.lookup_i(tag_lookup), .touch_i(tag_touch), .fill_i(tag_fill), .way_i(tag_way),
		.lease_i(lease), .dirty_i(tag_dirty), .hit_o(hit_tag), .hit_way_o(hit_way),
		.victim_way_o(victim_way), .victim_dirty_o(victim_dirty),
		.victim_tag_o(victim_tag), .victim_expired_o(victim_expired));

	lease_table lease_table_inst (
		.clock_i(clock_i), .rst_n_i(rst_n_i), .comm_i(comm_i), .ref_add_i(core_ref_add_i),
		.lease_o(lease), .defaulted_o(defaulted));

	cache_data_memory cache_mem_inst (
		.clock_i(clock_i), .addr_i(cache_add), .data_i(data_to_cache),
		.wren_i(cache_wren), .data_o(data_from_cache));

	// ram on a hit, controller word otherwise
	assign core_data_o = swap_flag ? data_from_cache : ctrl_core_data;

	cache_performance_controller perf_cont_inst (
		.clock_i(clock_i), .rst_n_i(rst_n_i), .hit_i(hit_flag), .miss_i(miss_flag),
		.writeback_i(wb_flag), .expired_i(expired_flag), .defaulted_i(defaulted_flag),
		.comm_i(comm_i), .comm_o(comm_o));

	lease_cache_controller cache_contr_inst (
		.clock_i(clock_i), .rst_n_i(rst_n_i), .enable_i(en_i),
		.core_req_i(core_req_i), .core_rw_i(core_rw_i), .core_tag_i(req_tag),
		.core_set_i(req_set), .core_word_i(req_word), .core_data_i(core_data_i),
		.core_done_o(core_done_o), .core_hit_o(hit_o), .core_data_o(ctrl_core_data),
		.tag_hit_i(hit_tag), .tag_hit_way_i(hit_way), .tag_victim_way_i(victim_way),
		.tag_victim_dirty_i(victim_dirty), .tag_victim_tag_i(victim_tag),
		.tag_victim_expired_i(victim_expired), .tag_lookup_o(tag_lookup),
		.tag_touch_o(tag_touch), .tag_fill_o(tag_fill), .tag_way_o(tag_way),
		.tag_dirty_o(tag_dirty), .lease_i(lease), .defaulted_i(defaulted),
		.cache_mem_data_i(data_from_cache), .cache_mem_add_o(cache_add),
		.cache_mem_rw_o(cache_wren), .cache_mem_data_o(data_to_cache),
		.buffer_read_ready_i(ready_read_i), .buffer_data_i(data_i), .buffer_read_ack_o(read_o),
		.buffer_write_ready_i(ready_write_i), .buffer_data_o(data_o),
		.buffer_write_ack_o(write_o), .mem_ready_i(ready_req_i), .mem_req_o(req_o),
		.mem_req_block_o(req_block_o), .mem_rw_o(rw_o), .mem_addr_o(add_o),
		.flag_hit_o(hit_flag), .flag_miss_o(miss_flag), .flag_writeback_o(wb_flag),
		.flag_expired_o(expired_flag), .flag_defaulted_o(defaulted_flag),
		.flag_swap_o(swap_flag));

endmodule

// File: lease_cache/lease_cache_controller.sv
`timescale 1ns/1ps

module lease_cache_controller (
	input  logic                                     clock_i,
	input  logic                                     rst_n_i,
	input  logic                                     enable_i,
	// core
	input  logic                                     core_req_i,
	input  logic                                     core_rw_i,
	input  logic [lease_cache_pkg::BW_TAG-1:0]       core_tag_i,
	input  logic [lease_cache_pkg::BW_SET-1:0]       core_set_i,
	input  logic [lease_cache_pkg::BW_BLOCK-1:0]     core_word_i,
	input  logic [31:0]                              core_data_i,
	output logic                                     core_done_o,
	output logic                                     core_hit_o,
	output logic [31:0]                              core_data_o,
	// tag memory
	input  logic                                     tag_hit_i,
	input  logic [lease_cache_pkg::BW_WAY-1:0]       tag_hit_way_i,
	input  logic [lease_cache_pkg::BW_WAY-1:0]       tag_victim_way_i,
	input  logic                                     tag_victim_dirty_i,
	input  logic [lease_cache_pkg::BW_TAG-1:0]       tag_victim_tag_i,
	input  logic                                     tag_victim_expired_i,
	output logic                                     tag_lookup_o,
	output logic                                     tag_touch_o,
	output logic                                     tag_fill_o,
	output logic [lease_cache_pkg::BW_WAY-1:0]       tag_way_o,
	output logic                                     tag_dirty_o,
	// lease table
	input  logic [lease_cache_pkg::BW_LEASE-1:0]     lease_i,
	input  logic                                     defaulted_i,
	// cache memory
	input  logic [31:0]                              cache_mem_data_i,
	output logic [lease_cache_pkg::BW_CACHE_ADDR-1:0] cache_mem_add_o,
	output logic                                     cache_mem_rw_o,
	output logic [31:0]                              cache_mem_data_o,
	// buffer
	input  logic                                     buffer_read_ready_i,
	input  logic [31:0]                              buffer_data_i,
	output logic                                     buffer_read_ack_o,
	input  logic                                     buffer_write_ready_i,
	output logic [31:0]                              buffer_data_o,
	output logic                                     buffer_write_ack_o,
	// command
	input  logic                                     mem_ready_i,
	output logic                                     mem_req_o,
	output logic                                     mem_req_block_o,
	output logic                                     mem_rw_o,
	output logic [lease_cache_pkg::BW_WORD_ADDR-1:0] mem_addr_o,
	// performance
	output logic                                     flag_hit_o,
	output logic                                     flag_miss_o,
	output logic                                     flag_writeback_o,
	output logic                                     flag_expired_o,
	output logic                                     flag_defaulted_o,
	output logic                                     flag_swap_o
);

	logic [2:0]                              state, next_state;
	logic                                    cmd_sent;   // command accepted in this state
	logic                                    primed;     // ram q matches word_cnt
	logic [lease_cache_pkg::BW_BLOCK-1:0]    word_cnt;
	logic                                    hit_q;
	logic [lease_cache_pkg::BW_WAY-1:0]      way_q;      // hit way or chosen victim
	logic [lease_cache_pkg::BW_TAG-1:0]      victim_tag_q;
	logic [31:0]                             data_q;     // word for the core off the buffer
	logic                                    take_hit, bypass, alloc, last_word, own_word;

	assign take_hit  = enable_i & tag_hit_i;
	assign bypass    = !enable_i || lease_i == '0;   // zero lease is never cached
	assign alloc     = state == lease_cache_pkg::ST_LOOKUP && !take_hit && !bypass;
	assign last_word = &word_cnt;
	assign own_word  = word_cnt == core_word_i;

	// next state
	// ----------------------------------------
	always_comb begin
		next_state = state;
		case (state)
			lease_cache_pkg::ST_IDLE: if (core_req_i) next_state = lease_cache_pkg::ST_LOOKUP;
			lease_cache_pkg::ST_LOOKUP:
				if (take_hit) next_state = lease_cache_pkg::ST_HIT;
				else if (bypass) next_state = lease_cache_pkg::ST_BYPASS;
				else if (tag_victim_dirty_i) next_state = lease_cache_pkg::ST_WRITEBACK;
				else next_state = lease_cache_pkg::ST_FILL_REQ;
			lease_cache_pkg::ST_WRITEBACK:
				if (buffer_write_ack_o && last_word) next_state = lease_cache_pkg::ST_FILL_REQ;
			lease_cache_pkg::ST_FILL_REQ: if (mem_ready_i) next_state = lease_cache_pkg::ST_FILL;
			lease_cache_pkg::ST_FILL:
				if (buffer_read_ack_o && last_word) next_state = lease_cache_pkg::ST_DONE;
			lease_cache_pkg::ST_BYPASS:
				if (buffer_read_ack_o || buffer_write_ack_o) next_state = lease_cache_pkg::ST_DONE;
			default: next_state = lease_cache_pkg::ST_IDLE;   // hit and done both finish here
		endcase
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= lease_cache_pkg::ST_IDLE;
			cmd_sent <= 1'b0;
			primed <= 1'b0;
			word_cnt <= '0;
			hit_q <= 1'b0;
			way_q <= '0;
		end else begin
			state <= next_state;
			cmd_sent <= (next_state == state) && (cmd_sent || (mem_req_o && mem_ready_i));
			primed <= state == lease_cache_pkg::ST_WRITEBACK && !buffer_write_ack_o;
			if (next_state != state) word_cnt <= '0;
			else word_cnt <= word_cnt + {1'b0, buffer_write_ack_o | buffer_read_ack_o};
			if (state == lease_cache_pkg::ST_LOOKUP) begin
				hit_q <= take_hit;
				way_q <= tag_hit_i ? tag_hit_way_i : tag_victim_way_i;
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (state == lease_cache_pkg::ST_LOOKUP) victim_tag_q <= tag_victim_tag_i;
		if (buffer_read_ack_o && (state == lease_cache_pkg::ST_BYPASS || own_word))
			data_q <= buffer_data_i;
	end

	// datapath
	// ----------------------------------------
	assign tag_lookup_o = state == lease_cache_pkg::ST_LOOKUP && enable_i;
	assign tag_touch_o  = state == lease_cache_pkg::ST_HIT;
	assign tag_fill_o   = state == lease_cache_pkg::ST_FILL && buffer_read_ack_o && last_word;
	assign tag_way_o    = way_q;
	assign tag_dirty_o  = core_rw_i;

	// lookup reads the hit way, block moves walk word_cnt
	assign cache_mem_add_o = {core_set_i,
		(state == lease_cache_pkg::ST_LOOKUP) ? tag_hit_way_i : way_q,
		(state == lease_cache_pkg::ST_WRITEBACK || state == lease_cache_pkg::ST_FILL)
			? word_cnt : core_word_i};
	assign cache_mem_rw_o   = (tag_touch_o && core_rw_i)
		|| (state == lease_cache_pkg::ST_FILL && buffer_read_ack_o);
	assign cache_mem_data_o = (tag_touch_o || (core_rw_i && own_word)) ? core_data_i
		: buffer_data_i;   // write miss merges the core word into the fill

	assign mem_req_o = !cmd_sent && (state == lease_cache_pkg::ST_WRITEBACK
		|| state == lease_cache_pkg::ST_FILL_REQ || state == lease_cache_pkg::ST_BYPASS);
	assign mem_req_block_o = state != lease_cache_pkg::ST_BYPASS;
	assign mem_rw_o = state == lease_cache_pkg::ST_WRITEBACK
		|| (state == lease_cache_pkg::ST_BYPASS && core_rw_i);
	always_comb begin
		case (state)
			lease_cache_pkg::ST_WRITEBACK: mem_addr_o = {victim_tag_q, core_set_i, 2'b00};
			lease_cache_pkg::ST_BYPASS:    mem_addr_o = {core_tag_i, core_set_i, core_word_i};
			default:                       mem_addr_o = {core_tag_i, core_set_i, 2'b00};
		endcase
	end

	assign buffer_write_ack_o = cmd_sent && buffer_write_ready_i
		&& ((state == lease_cache_pkg::ST_WRITEBACK && primed)
		|| (state == lease_cache_pkg::ST_BYPASS && core_rw_i));
	assign buffer_read_ack_o = buffer_read_ready_i && (state == lease_cache_pkg::ST_FILL
		|| (state == lease_cache_pkg::ST_BYPASS && cmd_sent && !core_rw_i));
	assign buffer_data_o = (state == lease_cache_pkg::ST_BYPASS) ? core_data_i : cache_mem_data_i;

	// core side
	assign core_done_o = state == lease_cache_pkg::ST_HIT || state == lease_cache_pkg::ST_DONE;
	assign core_hit_o  = core_done_o & hit_q;
	assign core_data_o = data_q;
	assign flag_swap_o = state == lease_cache_pkg::ST_HIT;   // ram q to the core

	// event strobes, one per request
	assign flag_hit_o       = state == lease_cache_pkg::ST_LOOKUP && take_hit;
	assign flag_miss_o      = state == lease_cache_pkg::ST_LOOKUP && !take_hit;
	assign flag_writeback_o = alloc && tag_victim_dirty_i;
	assign flag_expired_o   = alloc && tag_victim_expired_i;
	assign flag_defaulted_o = tag_lookup_o && defaulted_i;

endmodule

// File: lease_cache/lease_table.sv
`timescale 1ns/1ps

module lease_table (
	input  logic                                    clock_i,
	input  logic                                    rst_n_i,
	input  logic [31:0]                             comm_i,
	input  logic [lease_cache_pkg::BW_WORD_ADDR-1:0] ref_add_i,   // requesting instruction
	output logic [lease_cache_pkg::BW_LEASE-1:0]    lease_o,
	output logic                                    defaulted_o
);

	localparam int NUM_ENTRIES = 2 ** lease_cache_pkg::BW_REF_IDX;

	lease_cache_pkg::comm_word_u          comm;
	logic [lease_cache_pkg::BW_LEASE-1:0] lease_mem [NUM_ENTRIES];
	logic [NUM_ENTRIES-1:0]               entry_valid;
	logic [lease_cache_pkg::BW_LEASE-1:0] default_lease;   // zero after reset, so no caching
	logic [lease_cache_pkg::BW_REF_IDX-1:0] ref_idx;

	assign comm    = comm_i;
	assign ref_idx = ref_add_i[lease_cache_pkg::BW_REF_IDX-1:0];   // low bits index the table

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			entry_valid <= '0;
			default_lease <= '0;
		end else begin
			case (comm.lease_cfg.opcode)
				lease_cache_pkg::COMM_OP_NOP: ;
				lease_cache_pkg::COMM_OP_SET_LEASE:
					entry_valid[comm.lease_cfg.index] <= comm.lease_cfg.valid;
				lease_cache_pkg::COMM_OP_SET_DEFAULT: default_lease <= comm.lease_cfg.lease;
				default: ;   // counter reads are for the perf block
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (comm.lease_cfg.opcode == lease_cache_pkg::COMM_OP_SET_LEASE)
			lease_mem[comm.lease_cfg.index] <= comm.lease_cfg.lease;
	end

	assign defaulted_o = ~entry_valid[ref_idx];
	assign lease_o     = defaulted_o ? default_lease : lease_mem[ref_idx];

endmodule

// File: lease_cache/tag_memory_8way.sv
`timescale 1ns/1ps

module tag_memory_8way (
	input  logic                                clock_i,
	input  logic                                rst_n_i,
	input  logic [lease_cache_pkg::BW_SET-1:0]  set_i,
	input  logic [lease_cache_pkg::BW_TAG-1:0]  tag_i,
	input  logic                                lookup_i,  // counts down the other ways
	input  logic                                touch_i,   // hit way renew
	input  logic                                fill_i,    // new block in way_i
	input  logic [lease_cache_pkg::BW_WAY-1:0]  way_i,
	input  logic [lease_cache_pkg::BW_LEASE-1:0] lease_i,
	input  logic                                dirty_i,
	output logic                                hit_o,
	output logic [lease_cache_pkg::BW_WAY-1:0]  hit_way_o,
	output logic [lease_cache_pkg::BW_WAY-1:0]  victim_way_o,
	output logic                                victim_dirty_o,
	output logic [lease_cache_pkg::BW_TAG-1:0]  victim_tag_o,
	output logic                                victim_expired_o
);

	localparam int NUM_SETS = 2 ** lease_cache_pkg::BW_SET;
	localparam int NW = lease_cache_pkg::NUM_WAYS;

	logic [lease_cache_pkg::BW_TAG-1:0]   tag_q   [NUM_SETS][NW];
	logic [lease_cache_pkg::BW_LEASE-1:0] lease_q [NUM_SETS][NW];
	logic [NW-1:0]                        valid_q [NUM_SETS];
	logic [NW-1:0]                        dirty_q [NUM_SETS];
	logic [lease_cache_pkg::BW_LEASE-1:0] key;
	logic [lease_cache_pkg::BW_LEASE-1:0] min_key;

	// search
	// ----------------------------------------
	always_comb begin
		hit_o = 1'b0;
		hit_way_o = '0;
		min_key = '1;
		victim_way_o = '0;
		for (int w = NW - 1; w >= 0; w--) begin
			if (valid_q[set_i][w] && tag_q[set_i][w] == tag_i) begin
				hit_o = 1'b1;
				hit_way_o = w[lease_cache_pkg::BW_WAY-1:0];
			end
			// invalid ways rank as lease zero, ties go to the lower way
			key = valid_q[set_i][w] ? lease_q[set_i][w] : '0;
			if (key <= min_key) begin
				min_key = key;
				victim_way_o = w[lease_cache_pkg::BW_WAY-1:0];
			end
		end
	end

	assign victim_tag_o     = tag_q[set_i][victim_way_o];
	assign victim_dirty_o   = valid_q[set_i][victim_way_o] & dirty_q[set_i][victim_way_o];
	assign victim_expired_o = valid_q[set_i][victim_way_o] && lease_q[set_i][victim_way_o] == '0;

	// state update
	// ----------------------------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
				for (int w = 0; w < NW; w++)
					lease_q[s][w] <= '0;
			end
		end else begin
			for (int w = 0; w < NW; w++) begin
				if (lookup_i && !(hit_o && hit_way_o == w[lease_cache_pkg::BW_WAY-1:0])
						&& lease_q[set_i][w] != '0)
					lease_q[set_i][w] <= lease_q[set_i][w] - 1'b1;
			end
			if (touch_i) begin
				lease_q[set_i][way_i] <= lease_i;
				dirty_q[set_i][way_i] <= dirty_q[set_i][way_i] | dirty_i;  // sticky until evicted
			end
			if (fill_i) begin
				lease_q[set_i][way_i] <= lease_i;
				valid_q[set_i][way_i] <= 1'b1;
				dirty_q[set_i][way_i] <= dirty_i;   // write miss lands dirty
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (fill_i) tag_q[set_i][way_i] <= tag_i;
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the lease cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lease_cache_tb \
	-f all.f -o lease_cache_sim \
	&& ./obj_dir/lease_cache_sim | tee /dev/stderr | grep -q "Testbench passed" \
	&& echo "simulation result: PASS" \
	|| { echo "simulation result: FAIL"; exit 1; }

// File: verif/lease_cache_props.sv
`timescale 1ns/1ps

module lease_cache_props (
	input logic clock_i,
	input logic rst_n_i,
	input logic core_req_i,
	input logic core_done_o,
	input logic hit_o,
	input logic req_o,
	input logic ready_req_i,
	input logic read_o,
	input logic write_o
);

	// command stays up until the controller side takes it
	req_held: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		req_o && !ready_req_i |=> req_o) else $error("req_o dropped before ready_req_i");

	done_pulse: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		core_done_o |=> !core_done_o) else $error("core_done_o longer than one cycle");

	no_read_write: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		!(read_o && write_o)) else $error("read_o and write_o together");

	// lookup cycle, then ram read cycle
	hit_latency: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		core_done_o && hit_o |-> $past(core_req_i, 2) && !$past(core_req_i, 3))
		else $error("hit done not 2 cycles after request");

endmodule

// File: verif/lease_cache_tb.sv
`timescale 1ns/1ps

module lease_cache_tb;

	localparam int TIMEOUT_CYCLES = 20000;   // ~30 requests, worst case a few hundred cycles each

	logic clock_i, rst_n_i, core_req_i, core_rw_i, en_i;
	logic ready_req_i, ready_write_i, ready_read_i;
	logic [31:0] comm_i, comm_o, core_data_i, core_data_o, data_i, data_o;
	logic [15:0] core_ref_add_i, core_add_i, add_o;
	logic core_done_o, hit_o, req_o, req_block_o, rw_o, write_o, read_o;
	logic [31:0] mem_model [65536];
	logic [15:0] mem_base, mem_ptr;
	logic cmd_rw, cmd_block;   // last accepted command
	logic [31:0] rnd;
	integer seed = 32'h3d6ea633;
	int cycle_cnt = 0;
	logic [lease_cache_pkg::BW_CNT-1:0] exp_hit, exp_miss, exp_wb, exp_expired, exp_def;

	lease_cache_8w lease_cache_8w_inst (.*);

	bind lease_cache_8w lease_cache_props props_inst (.clock_i(clock_i), .rst_n_i(rst_n_i),
		.core_req_i(core_req_i), .core_done_o(core_done_o), .hit_o(hit_o), .req_o(req_o),
		.ready_req_i(ready_req_i), .read_o(read_o), .write_o(write_o));

	initial begin
		clock_i = 1'b0;
		forever #4 clock_i = ~clock_i;
	end

	initial begin
		forever begin
			@(posedge clock_i);
			cycle_cnt++;
			if (cycle_cnt >= TIMEOUT_CYCLES) begin
				$display("Run exceeded %0d cycles without finishing", TIMEOUT_CYCLES);
				$display("Testbench failed");
				$fatal(1);
			end
		end
	end

	// memory buffer model
	// ----------------------------------------
	initial begin
		ready_req_i = 1'b0;
		ready_read_i = 1'b0;
		ready_write_i = 1'b0;
		data_i = '0;
		mem_base = '0;
		mem_ptr = '0;
		cmd_rw = 1'b0;
		cmd_block = 1'b0;
		forever begin
			@(negedge clock_i);
			data_i = mem_model[mem_base + mem_ptr];
			rnd = $random(seed);
			ready_req_i = rnd[0] | rnd[1];     // mostly ready
			ready_read_i = rnd[2] | rnd[3];
			ready_write_i = rnd[4] | rnd[5];
			#1;   // outputs settled, these events land on the next rising edge
			if (rst_n_i && req_o && ready_req_i) begin
				mem_base = add_o;
				mem_ptr = '0;
				cmd_rw = rw_o;
				cmd_block = req_block_o;
			end
			if (read_o) begin
				check_bit("rw_o", cmd_rw, 1'b0);   // reads only follow a read command
				mem_ptr++;
			end
			if (write_o) begin
				check_bit("rw_o", cmd_rw, 1'b1);
				mem_model[mem_base + mem_ptr] = data_o;
				mem_ptr++;
			end
		end
	end

	// compare tasks
	// ----------------------------------------
	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_count(input string name, input logic [lease_cache_pkg::BW_CNT-1:0] got,
			input logic [lease_cache_pkg::BW_CNT-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	// drivers
	// ----------------------------------------
	task automatic send_comm(input lease_cache_pkg::comm_word_u w);
		@(negedge clock_i);
		comm_i = w;
		@(negedge clock_i);
		comm_i = '0;   // back to nop
	endtask

	task automatic program_lease(input logic [3:0] idx, input logic [7:0] lease);
		lease_cache_pkg::comm_word_u w;
		w = '0;
		w.lease_cfg.opcode = lease_cache_pkg::COMM_OP_SET_LEASE;
		w.lease_cfg.valid = 1'b1;
		w.lease_cfg.index = idx;
		w.lease_cfg.lease = lease;
		send_comm(w);
	endtask

	task automatic read_counter(input string name, input logic [2:0] sel,
			input logic [lease_cache_pkg::BW_CNT-1:0] exp);
		lease_cache_pkg::comm_word_u w;
		w = '0;
		w.cnt_sel.opcode = lease_cache_pkg::COMM_OP_READ_CNT;
		w.cnt_sel.sel = sel;
		@(negedge clock_i);
		comm_i = w;
		@(negedge clock_i);
		comm_i = '0;
		check_count(name, comm_o, exp);
	endtask

	// one core request, hit and data checked at done
	task automatic access(input logic [15:0] ref_add, input logic rw, input logic [15:0] add,
			input logic [31:0] wdata, input logic exp_hit_bit, input logic [31:0] exp_data);
		int cycles;
		cycles = 0;
		@(negedge clock_i);
		core_ref_add_i = ref_add;
		core_rw_i = rw;
		core_add_i = add;
		core_data_i = wdata;
		core_req_i = 1'b1;
		while (!core_done_o || cycles == 0) begin
			@(negedge clock_i);
			cycles++;
		end
		check_bit("hit_o", hit_o, exp_hit_bit);
		if (!rw) check_word("core_data_o", core_data_o, exp_data);
		if (exp_hit_bit) check_count("hit latency", cycles, 2);
		core_req_i = 1'b0;
		if (exp_hit_bit) exp_hit++;
		else exp_miss++;
	endtask

	function automatic logic [15:0] word_add(input int tag, input int set, input int word);
		return 16'((tag << 5) | (set << 2) | word);
	endfunction

	// tests
	// ----------------------------------------
	task automatic test_miss_then_hit();
		logic [15:0] a;
		a = word_add(1, 0, 2);
		program_lease(4'd1, 8'd5);
		access(16'h0001, 1'b0, a, '0, 1'b0, mem_model[a]);
		check_bit("req_block_o", cmd_block, 1'b1);   // whole block fill
		access(16'h0001, 1'b0, a, '0, 1'b1, mem_model[a]);
	endtask

	task automatic test_writeback();
		logic [15:0] b;
		b = word_add(2, 1, 1);
		program_lease(4'd2, 8'd200);
		access(16'h0002, 1'b0, b, '0, 1'b0, mem_model[b]);    // bring the block in
		access(16'h0002, 1'b1, b, 32'hcafe0001, 1'b1, '0);   // write hit, way now dirty
		access(16'h0002, 1'b0, b, '0, 1'b1, 32'hcafe0001);
		for (int t = 3; t <= 10; t++)
			access(16'h0002, 1'b0, word_add(t, 1, 0), '0, 1'b0, mem_model[word_add(t, 1, 0)]);
		exp_wb++;   // eighth fill evicts the dirty way, lowest lease by then
		check_word("mem_model[b]", mem_model[b], 32'hcafe0001);
	endtask

	task automatic test_zero_lease();
		logic [15:0] c;
		c = word_add(20, 2, 3);
		repeat (2) begin
			access(16'h0007, 1'b0, c, '0, 1'b0, mem_model[c]);
			check_bit("req_block_o", cmd_block, 1'b0);   // single word bypass
			exp_def++;
		end
	endtask

	task automatic test_expiry();
		logic [15:0] d;
		d = word_add(30, 3, 0);
		program_lease(4'd3, 8'd1);
		access(16'h0003, 1'b0, d, '0, 1'b0, mem_model[d]);
		for (int t = 40; t <= 41; t++) begin   // uncached, still counts the set down
			access(16'h0007, 1'b0, word_add(t, 3, 1), '0, 1'b0, mem_model[word_add(t, 3, 1)]);
			exp_def++;
		end
		access(16'h0003, 1'b0, word_add(33, 3, 2), '0, 1'b0, mem_model[word_add(33, 3, 2)]);
		exp_expired++;
		access(16'h0003, 1'b0, d, '0, 1'b0, mem_model[d]);   // gone, so a miss
	endtask

	task automatic test_counters();
		read_counter("hit counter", lease_cache_pkg::CNT_HIT, exp_hit);
		read_counter("miss counter", lease_cache_pkg::CNT_MISS, exp_miss);
		read_counter("writeback counter", lease_cache_pkg::CNT_WB, exp_wb);
		read_counter("expired counter", lease_cache_pkg::CNT_EXPIRED, exp_expired);
		read_counter("defaulted counter", lease_cache_pkg::CNT_DEFAULTED, exp_def);
	endtask

	initial begin
		rst_n_i = 1'b0;
		core_req_i = 1'b0;
		core_rw_i = 1'b0;
		core_ref_add_i = '0;
		core_add_i = '0;
		core_data_i = '0;
		comm_i = '0;
		en_i = 1'b1;
		{exp_hit, exp_miss, exp_wb, exp_expired, exp_def} = '0;
		for (int a = 0; a < 65536; a++)
			mem_model[a] = {16'h0, a[15:0]} ^ 32'h5a5a0000;
		repeat (16) @(posedge clock_i);
		@(negedge clock_i);
		rst_n_i = 1'b1;
		test_miss_then_hit();
		test_writeback();
		test_zero_lease();
		test_expiry();
		test_counters();
		$display("Testbench passed");
		$finish;
	end

endmodule
